// File: Makefile
# Verilator build and run for the receive MAC

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rx_mac_tb
FILELIST = rx_mac_top.f
BUILD    = obj_dir
PASS_MSG = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: rtl/rx_byte_fifo.sv
// --------------------------------------------------
// Receive byte queue
// Pairs PHY nibbles into bytes, queues them with eof
// --------------------------------------------------

`default_nettype none

module rx_byte_fifo #(
	parameter int FIFO_DEPTH = rx_mac_pkg::FIFO_DEPTH_DEFAULT
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst,
	input  wire                   phy_dv_i,
	input  wire [3:0]             phy_rx_data_i,
	input  wire                   phy_rx_er_i,
	input  wire                   ack_i,
	output rx_mac_pkg::rx_byte_t  head_o,
	output logic                  empty_o,
	output logic                  fifo_full_o
);
	import rx_mac_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	rx_byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic dv_q;
	logic have_low;
	logic [3:0] low_nib;
	logic byte_stb;
	logic [7:0] byte_data;
	logic eof_stb;
	logic eof_bad;
	logic err_seen;
	logic drop_seen;
	logic wrote_byte;
	logic room;
	logic byte_wr;
	logic drop_now;
	logic wr_en;
	rx_byte_t wr_entry;

	// Two free entries needed for a byte, so the eof always fits
	assign room = count <= CNT_W'(FIFO_DEPTH - 2);
	assign fifo_full_o = ~room;
	assign byte_wr = byte_stb & room;
	assign drop_now = byte_stb & ~room;
	assign wr_en = byte_wr | eof_stb;

	// --------------------------------------------------
	// Nibble assembly and frame status
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			dv_q <= 1'b0;
			have_low <= 1'b0;
			byte_stb <= 1'b0;
			eof_stb <= 1'b0;
			err_seen <= 1'b0;
			drop_seen <= 1'b0;
			wrote_byte <= 1'b0;
		end else begin
			dv_q <= phy_dv_i;
			byte_stb <= 1'b0;
			eof_stb <= 1'b0;
			if (drop_now)
				drop_seen <= 1'b1;
			if (byte_wr)
				wrote_byte <= 1'b1;
			if (phy_dv_i) begin
				if (phy_rx_er_i)
					err_seen <= 1'b1;
				byte_stb <= have_low;
				have_low <= ~have_low;
			end else if (dv_q) begin
				// Frames that queued no byte leave no eof behind
				eof_stb <= wrote_byte | byte_wr;
				have_low <= 1'b0;
				err_seen <= 1'b0;
				drop_seen <= 1'b0;
				wrote_byte <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (phy_dv_i && !have_low)
			low_nib <= phy_rx_data_i;
		if (phy_dv_i && have_low)
			byte_data <= {phy_rx_data_i, low_nib};
		// A drop in this very cycle still belongs to the ending frame
		if (!phy_dv_i && dv_q)
			eof_bad <= err_seen | drop_seen | drop_now | have_low;
	end

	// --------------------------------------------------
	// Circular buffer
	// --------------------------------------------------
	always_comb begin
		wr_entry.eof = eof_stb;
		wr_entry.data = eof_stb ? {7'd0, eof_bad} : byte_data;
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (ack_i)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !ack_i)
				count <= count + 1'b1;
			else if (!wr_en && ack_i)
				count <= count - 1'b1;
		end
	end

	assign head_o = mem[rd_ptr];
	assign empty_o = count == '0;

	// Writer must never pop an empty queue
	a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (sys_rst)
		ack_i |-> !empty_o);

	// Room reserved for the eof keeps every write in bounds
	a_no_overflow: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wr_en |-> count < CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: rtl/rx_frame_writer.sv
// --------------------------------------------------
// Receive frame writer
// Packs queued bytes into words and writes them out
// --------------------------------------------------

`default_nettype none

module rx_frame_writer #(
	parameter int MTU = rx_mac_pkg::MTU_DEFAULT
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst,
	input  wire rx_mac_pkg::rx_byte_t head_i,
	input  wire                   empty_i,
	output logic                  ack_o,
	input  wire                   slot_valid_i,
	input  wire [29:0]            slot_adr_i,
	output rx_mac_pkg::wb_req_t   wb_req_o,
	output logic                  wb_stb_o,
	input  wire                   wb_ack_i,
	output logic                  count_reset_o,
	output logic                  count_incr_o,
	output logic                  frame_end_o
);
	import rx_mac_pkg::*;

	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		LOADBYTE = 3'd1,
		WBSTROBE = 3'd2,
		SENDLAST = 3'd3,
		NOMORE   = 3'd4
	} state_t;

	state_t state;
	state_t next_state;

	logic in_frame;
	logic start_of_frame;
	logic end_of_frame;
	logic load_en;
	logic next_adr;
	logic [1:0] lane;
	logic [LEN_W-1:0] place;
	logic [29:0] word_adr;
	logic [31:0] wb_dat;
	logic full_word;
	logic empty_word;
	logic still_place;

	assign full_word = &lane;
	assign empty_word = lane == 2'd0;
	assign still_place = place != '0;
	assign count_incr_o = load_en;
	assign wb_req_o = '{adr: {word_adr, 2'b00}, dat: wb_dat};

	// --------------------------------------------------
	// Frame tracking, lane and remaining place
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			in_frame <= 1'b0;
			lane <= 2'd0;
			place <= LEN_W'(MTU);
		end else begin
			state <= next_state;
			if (start_of_frame)
				in_frame <= 1'b1;
			else if (end_of_frame)
				in_frame <= 1'b0;
			if (start_of_frame) begin
				lane <= 2'd0;
				place <= LEN_W'(MTU);
			end else if (load_en) begin
				lane <= lane + 2'd1;
				place <= place - 1'b1;
			end
		end
	end

	// First byte of each word lands in the top lane
	always_ff @(posedge sys_clk) begin
		if (start_of_frame)
			word_adr <= slot_adr_i;
		else if (next_adr)
			word_adr <= word_adr + 30'd1;
		if (load_en) begin
			case (lane)
				2'd0: wb_dat[31:24] <= head_i.data;
				2'd1: wb_dat[23:16] <= head_i.data;
				2'd2: wb_dat[15:8] <= head_i.data;
				default: wb_dat[7:0] <= head_i.data;
			endcase
		end
	end

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_comb begin
		next_state = state;
		ack_o = 1'b0;
		count_reset_o = 1'b0;
		frame_end_o = 1'b0;
		start_of_frame = 1'b0;
		end_of_frame = 1'b0;
		load_en = 1'b0;
		wb_stb_o = 1'b0;
		next_adr = 1'b0;
		case (state)
			IDLE: begin
				if (!empty_i && slot_valid_i) begin
					if (head_i.eof) begin
						ack_o = 1'b1;
						// Stray eof outside a frame is simply dropped
						if (in_frame) begin
							end_of_frame = 1'b1;
							if (head_i.data[0])
								count_reset_o = 1'b1;
							else if (empty_word)
								frame_end_o = 1'b1;
							else
								next_state = SENDLAST;
						end
					end else if (!in_frame) begin
						start_of_frame = 1'b1;
						next_state = LOADBYTE;
					end else if (still_place) begin
						next_state = LOADBYTE;
					end else begin
						// One byte past the MTU, discard the rest
						next_state = NOMORE;
					end
				end
			end
			LOADBYTE: begin
				load_en = 1'b1;
				ack_o = 1'b1;
				next_state = full_word ? WBSTROBE : IDLE;
			end
			WBSTROBE: begin
				wb_stb_o = 1'b1;
				if (wb_ack_i) begin
					next_adr = 1'b1;
					next_state = IDLE;
				end
			end
			SENDLAST: begin
				wb_stb_o = 1'b1;
				if (wb_ack_i) begin
					frame_end_o = 1'b1;
					next_state = IDLE;
				end
			end
			NOMORE: begin
				if (!empty_i) begin
					ack_o = 1'b1;
					if (head_i.eof) begin
						count_reset_o = 1'b1;
						end_of_frame = 1'b1;
						next_state = IDLE;
					end
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// Request held steady until the bus answers
	a_req_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_req_o));

endmodule

`default_nettype wire

// File: rtl/rx_mac_pkg.sv
// --------------------------------------------------
// Receive MAC shared types
// Queue entry, bus request and default sizes
// --------------------------------------------------

`default_nettype none

package rx_mac_pkg;

	// --------------------------------------------------
	// Sizes
	// --------------------------------------------------

	// Largest frame stored, in bytes
	localparam int MTU_DEFAULT = 1500;

	// Entries in the byte queue
	localparam int FIFO_DEPTH_DEFAULT = 16;

	// Width of the byte count, wide enough for the MTU
	localparam int LEN_W = 11;

	// --------------------------------------------------
	// Queue entry
	// --------------------------------------------------

	// With eof set, data[0] flags a bad frame and the other bits are zero
	typedef struct packed {
		logic       eof;
		logic [7:0] data;
	} rx_byte_t;

	// --------------------------------------------------
	// Bus request
	// --------------------------------------------------

	// Byte address, always word aligned
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

endpackage

`default_nettype wire

// File: rtl/rx_mac_top.sv
// --------------------------------------------------
// Receive MAC top level
// PHY in, one host slot, Wishbone master out
// --------------------------------------------------

`default_nettype none

module rx_mac_top #(
	parameter int MTU        = rx_mac_pkg::MTU_DEFAULT,
	parameter int FIFO_DEPTH = rx_mac_pkg::FIFO_DEPTH_DEFAULT
) (
	input  wire                          sys_clk,
	input  wire                          sys_rst,
	// PHY receive side
	input  wire                          phy_dv_i,
	input  wire [3:0]                    phy_rx_data_i,
	input  wire                          phy_rx_er_i,
	// Host slot
	input  wire                          slot_arm_i,
	input  wire [29:0]                   slot_adr_i,
	output logic                         slot_done_o,
	output logic [rx_mac_pkg::LEN_W-1:0] slot_len_o,
	// Memory bus
	output rx_mac_pkg::wb_req_t          wb_req_o,
	output logic                         wb_stb_o,
	input  wire                          wb_ack_i,
	output logic                         fifo_full_o
);
	import rx_mac_pkg::*;

	rx_byte_t head;
	logic empty;
	logic ack;
	logic slot_valid;
	logic [29:0] slot_adr;
	logic count_reset;
	logic count_incr;
	logic frame_end;

	rx_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_byte_fifo (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.phy_dv_i(phy_dv_i),
		.phy_rx_data_i(phy_rx_data_i),
		.phy_rx_er_i(phy_rx_er_i),
		.ack_i(ack),
		.head_o(head),
		.empty_o(empty),
		.fifo_full_o(fifo_full_o)
	);

	rx_frame_writer #(
		.MTU(MTU)
	) u_frame_writer (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.head_i(head),
		.empty_i(empty),
		.ack_o(ack),
		.slot_valid_i(slot_valid),
		.slot_adr_i(slot_adr),
		.wb_req_o(wb_req_o),
		.wb_stb_o(wb_stb_o),
		.wb_ack_i(wb_ack_i),
		.count_reset_o(count_reset),
		.count_incr_o(count_incr),
		.frame_end_o(frame_end)
	);

	rx_slot_ctrl u_slot_ctrl (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.slot_arm_i(slot_arm_i),
		.slot_adr_i(slot_adr_i),
		.count_reset_i(count_reset),
		.count_incr_i(count_incr),
		.frame_end_i(frame_end),
		.slot_valid_o(slot_valid),
		.slot_adr_o(slot_adr),
		.slot_done_o(slot_done_o),
		.slot_len_o(slot_len_o)
	);
endmodule

`default_nettype wire

// File: rtl/rx_slot_ctrl.sv
// --------------------------------------------------
// Receive slot control
// Host arms one slot, writer reports its outcome
// --------------------------------------------------

`default_nettype none

module rx_slot_ctrl (
	input  wire                          sys_clk,
	input  wire                          sys_rst,
	input  wire                          slot_arm_i,
	input  wire [29:0]                   slot_adr_i,
	input  wire                          count_reset_i,
	input  wire                          count_incr_i,
	input  wire                          frame_end_i,
	output logic                         slot_valid_o,
	output logic [29:0]                  slot_adr_o,
	output logic                         slot_done_o,
	output logic [rx_mac_pkg::LEN_W-1:0] slot_len_o
);
	import rx_mac_pkg::*;

	logic armed;
	logic done;
	logic [LEN_W-1:0] count;

	// Slot accepts data only while armed and not yet filled
	assign slot_valid_o = armed & ~done;
	assign slot_done_o = done;

	// --------------------------------------------------
	// Arm, done and running byte count
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			armed <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (slot_arm_i) begin
			// Re-arming starts a fresh slot
			armed <= 1'b1;
			done <= 1'b0;
			count <= '0;
		end else begin
			if (count_reset_i)
				count <= '0;
			else if (count_incr_i)
				count <= count + 1'b1;
			if (frame_end_i)
				done <= 1'b1;
		end
	end

	// --------------------------------------------------
	// Slot address and reported length
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (slot_arm_i)
			slot_adr_o <= slot_adr_i;
		// Count already holds the last byte when the frame ends
		if (frame_end_i && !slot_arm_i)
			slot_len_o <= count;
	end

endmodule

`default_nettype wire

// File: rx_mac_top.f
rtl/rx_mac_pkg.sv
rtl/rx_byte_fifo.sv
rtl/rx_frame_writer.sv
rtl/rx_slot_ctrl.sv
rtl/rx_mac_top.sv
tb/rx_mac_tb.sv

// File: tb/rx_mac_tb.sv
// --------------------------------------------------
// Receive MAC testbench
// PHY driver, Wishbone memory model, directed tests
// --------------------------------------------------

`default_nettype none

module rx_mac_tb;
	import rx_mac_pkg::*;

	localparam int TB_MTU = 64;
	localparam int WAIT_LIMIT = 2000;
	localparam int SETTLE_CYCLES = 60;
	localparam logic [31:0] SEED = 32'he5d6_8e08;

	logic sys_clk;
	logic sys_rst;
	logic phy_dv;
	logic [3:0] phy_data;
	logic phy_er;
	logic slot_arm;
	logic [29:0] slot_adr;
	logic slot_done;
	logic [LEN_W-1:0] slot_len;
	wb_req_t wb_req;
	logic wb_stb;
	logic wb_ack = 1'b0;
	logic fifo_full;

	// Word memory keyed by byte address
	logic [31:0] mem [logic [31:0]];
	logic [31:0] byte_state;
	logic [31:0] stall_state = SEED;
	logic [7:0] frame_q [$];
	logic stall_mode;
	logic host_armed;
	logic strobe_seen = 1'b0;
	logic [1:0] delay_left = 2'd0;
	logic [31:0] limit_adr;

	rx_mac_top #(
		.MTU(TB_MTU),
		.FIFO_DEPTH(FIFO_DEPTH_DEFAULT)
	) u_rx_mac_top (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.phy_dv_i(phy_dv),
		.phy_rx_data_i(phy_data),
		.phy_rx_er_i(phy_er),
		.slot_arm_i(slot_arm),
		.slot_adr_i(slot_adr),
		.slot_done_o(slot_done),
		.slot_len_o(slot_len),
		.wb_req_o(wb_req),
		.wb_stb_o(wb_stb),
		.wb_ack_i(wb_ack),
		.fifo_full_o(fifo_full)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] adr);
		return mem.exists(adr) ? mem[adr] : 32'hxxxx_xxxx;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			report_failure($sformatf("Mismatch in %s: expected %08h, actual %08h",
				name, exp, act));
	endtask

	task automatic check_len(input string name, input logic [LEN_W-1:0] exp,
		input logic [LEN_W-1:0] act);
		if (act !== exp)
			report_failure($sformatf("Mismatch in %s: expected %0d, actual %0d",
				name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("Mismatch in %s: expected %b, actual %b",
				name, exp, act));
	endtask

	// --------------------------------------------------
	// Memory model acking each strobe once
	// --------------------------------------------------
	always @(negedge sys_clk) begin
		if (wb_ack) begin
			wb_ack = 1'b0;
			strobe_seen = 1'b0;
		end else if (wb_stb && !sys_rst) begin
			if (!strobe_seen) begin
				strobe_seen = 1'b1;
				stall_state = lcg_next(stall_state);
				delay_left = stall_mode ? stall_state[17:16] : 2'd0;
			end
			if (delay_left != 2'd0) begin
				delay_left = delay_left - 2'd1;
			end else begin
				if (!host_armed)
					report_failure("Bus write seen while no slot was armed");
				if (wb_req.adr >= limit_adr)
					report_failure("Bus write landed beyond the MTU limit of the slot");
				mem[wb_req.adr] = wb_req.dat;
				wb_ack = 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// PHY and host drivers
	// --------------------------------------------------
	task automatic build_frame(input int n);
		frame_q.delete();
		for (int i = 0; i < n; i++) begin
			byte_state = lcg_next(byte_state);
			frame_q.push_back(byte_state[23:16]);
		end
	endtask

	// Low nibble first, err_nib below zero means a clean frame
	task automatic send_frame(input logic [7:0] bytes [$], input int err_nib);
		for (int i = 0; i < bytes.size(); i++) begin
			for (int h = 0; h < 2; h++) begin
				@(negedge sys_clk);
				phy_dv = 1'b1;
				phy_data = (h == 0) ? bytes[i][3:0] : bytes[i][7:4];
				phy_er = (2 * i + h) == err_nib;
			end
		end
		@(negedge sys_clk);
		phy_dv = 1'b0;
		phy_data = 4'h0;
		phy_er = 1'b0;
		repeat (4) @(negedge sys_clk);
	endtask

	task automatic arm_slot(input logic [29:0] adr);
		@(negedge sys_clk);
		slot_adr = adr;
		slot_arm = 1'b1;
		host_armed = 1'b1;
		@(negedge sys_clk);
		slot_arm = 1'b0;
	endtask

	task automatic wait_done(input string name);
		int cycles;
		cycles = 0;
		while (slot_done !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (slot_done !== 1'b1)
			report_failure({"Timed out waiting for slot done in ", name});
		host_armed = 1'b0;
	endtask

	task automatic hold_not_done(input string name);
		for (int c = 0; c < SETTLE_CYCLES; c++) begin
			@(negedge sys_clk);
			check_bit(name, 1'b0, slot_done);
		end
	endtask

	// Big-endian packing, first byte in bits 31:24
	task automatic check_frame(input string name, input logic [31:0] base, input int n);
		logic [31:0] exp;
		logic [31:0] mask;
		for (int w = 0; w < n / 4; w++) begin
			exp = {frame_q[4 * w], frame_q[4 * w + 1], frame_q[4 * w + 2], frame_q[4 * w + 3]};
			check_word(name, exp, read_word(base + 32'(4 * w)));
		end
		if (n % 4 != 0) begin
			exp = '0;
			mask = '0;
			for (int k = 0; k < n % 4; k++) begin
				exp[31 - 8 * k -: 8] = frame_q[4 * (n / 4) + k];
				mask[31 - 8 * k -: 8] = 8'hff;
			end
			check_word(name, exp, read_word(base + 32'(4 * (n / 4))) & mask);
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic test_good_frame();
		arm_slot(30'h100);
		build_frame(48);
		send_frame(frame_q, -1);
		wait_done("good frame");
		check_frame("good frame data", 32'h400, 48);
		check_len("good frame length", LEN_W'(48), slot_len);
	endtask

	task automatic test_partial_word();
		arm_slot(30'h200);
		build_frame(37);
		send_frame(frame_q, -1);
		wait_done("partial word");
		check_frame("partial word data", 32'h800, 37);
		check_len("partial word length", LEN_W'(37), slot_len);
	endtask

	task automatic test_phy_error();
		arm_slot(30'h300);
		build_frame(24);
		send_frame(frame_q, 20);
		hold_not_done("phy error discard");
		// Slot stays armed, next frame starts over at the base
		build_frame(20);
		send_frame(frame_q, -1);
		wait_done("frame after phy error");
		check_frame("frame after phy error", 32'hc00, 20);
		check_len("frame after phy error length", LEN_W'(20), slot_len);
	endtask

	task automatic test_oversize();
		arm_slot(30'h400);
		limit_adr = 32'h1000 + 32'(TB_MTU);
		build_frame(80);
		send_frame(frame_q, -1);
		hold_not_done("oversize discard");
		build_frame(16);
		send_frame(frame_q, -1);
		wait_done("frame after oversize");
		check_frame("frame after oversize", 32'h1000, 16);
		check_len("frame after oversize length", LEN_W'(16), slot_len);
		limit_adr = '1;
	endtask

	task automatic test_ack_stalls();
		stall_mode = 1'b1;
		// Slot still done, so this frame backs up the queue and loses bytes
		build_frame(20);
		send_frame(frame_q, -1);
		check_bit("queue full before arming", 1'b1, fifo_full);
		arm_slot(30'h500);
		hold_not_done("overflowed frame discard");
		check_bit("queue drained after arming", 1'b0, fifo_full);
		build_frame(32);
		send_frame(frame_q, -1);
		wait_done("ack stalls");
		check_frame("ack stalls data", 32'h1400, 32);
		check_len("ack stalls length", LEN_W'(32), slot_len);
		stall_mode = 1'b0;
	endtask

	initial begin
		sys_rst = 1'b1;
		phy_dv = 1'b0;
		phy_data = 4'h0;
		phy_er = 1'b0;
		slot_arm = 1'b0;
		slot_adr = '0;
		stall_mode = 1'b0;
		host_armed = 1'b0;
		limit_adr = '1;
		byte_state = SEED;
		repeat (16) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		test_good_frame();
		test_partial_word();
		test_phy_error();
		test_oversize();
		test_ack_stalls();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
